/* verilog/core_config.svh */
`ifndef CORE_CONFIG_SVH
`define CORE_CONFIG_SVH

// issue queue entries, also the input credits the sender holds after reset
`define CORE_QUEUE_DEPTH 4

// store credits held by execute after reset
`define CORE_STORE_CREDITS 2

`endif

/* verilog/core_pkg.sv */
`default_nettype none

package core_pkg;

    typedef logic [31:0] word_t;

    typedef logic [2:0] reg_index_t;

    // codes outside this list execute as NOP
    typedef enum logic [5:0]
    {
        NOP   = 6'd0,
        ADD   = 6'd1,
        ADDC  = 6'd2,
        SUB   = 6'd3,
        AND   = 6'd4,
        OR    = 6'd5,
        XOR   = 6'd6,
        SHL   = 6'd7,
        SHR   = 6'd8,
        LDI   = 6'd9,
        CMPEQ = 6'd10,
        CMPLT = 6'd11,
        SEL   = 6'd12,
        STORE = 6'd13
    } opcode_e;

    // bit 31 down to bit 0
    typedef struct packed
    {
        logic [15:0] value;
        logic        hl;
        reg_index_t  rd;
        reg_index_t  rb;
        reg_index_t  ra;
        opcode_e     opcode;
    } instr_t;

endpackage

`default_nettype wire

/* verilog/core_ifs.sv */
`timescale 1ns/100ps
`default_nettype none

// register file read side, combinational
interface rd_port_if;
    core_pkg::reg_index_t ra;
    core_pkg::reg_index_t rb;
    core_pkg::word_t      a_data;
    core_pkg::word_t      b_data;
    logic                 flag_a;
    logic                 flag_b;

    modport regs (input ra, rb, output a_data, b_data, flag_a, flag_b);
    modport reader (output ra, rb, input a_data, b_data, flag_a, flag_b);
endinterface

// writeback from execute, also the bypass source for decode
interface wb_if;
    logic                 enable;
    core_pkg::reg_index_t index;
    core_pkg::word_t      data;
    logic                 flag;

    modport source (output enable, index, data, flag);
    modport sink (input enable, index, data, flag);
    modport monitor (input enable, index, data, flag);
endinterface

// execute input register, owned by decode
interface stage_if;
    logic                 valid;
    core_pkg::opcode_e    opcode;
    core_pkg::reg_index_t rd;
    logic                 hl;
    logic [15:0]          value;
    core_pkg::word_t      a;
    core_pkg::word_t      b;
    logic                 flag_a;
    logic                 stall;

    modport source (output valid, opcode, rd, hl, value, a, b, flag_a, input stall);
    modport sink (input valid, opcode, rd, hl, value, a, b, flag_a, output stall);
endinterface

`default_nettype wire

/* verilog/issue_queue.sv */
`timescale 1ns/100ps
`default_nettype none
`include "core_config.svh"

module issue_queue
(
    input  logic              clock,
    input  logic              arst_n,
    input  logic              instr_valid,
    input  core_pkg::word_t   instr,
    output logic              in_credit,
    output logic              head_valid,
    output core_pkg::instr_t  head,
    input  logic              pop
);

    localparam int DEPTH = `CORE_QUEUE_DEPTH;
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    core_pkg::word_t  mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;

    assign head_valid = (count != '0);
    assign head       = core_pkg::instr_t'(mem[rd_ptr]);

    // sender never exceeds its credits, so no full check
    always_ff @(posedge clock)
    begin
        if (instr_valid)
        begin
            mem[wr_ptr] <= instr;
        end
    end

    always_ff @(posedge clock or negedge arst_n)
    begin
        if (!arst_n)
        begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            count     <= '0;
            in_credit <= 1'b0;
        end
        else
        begin
            if (instr_valid)
            begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop)
            begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({instr_valid, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            // one credit back per popped entry
            in_credit <= pop;
        end
    end

endmodule

`default_nettype wire

/* verilog/reg_file.sv */
`timescale 1ns/100ps
`default_nettype none

module reg_file
(
    input  logic      clock,
    input  logic      arst_n,
    rd_port_if.regs   rd,
    wb_if.sink        wb
);

    core_pkg::word_t regs  [8];
    logic [7:0]      flags;

    always_ff @(posedge clock or negedge arst_n)
    begin
        if (!arst_n)
        begin
            for (int i = 0; i < 8; i++)
            begin
                regs[i] <= '0;
            end
            flags <= '0;
        end
        else if (wb.enable)
        begin
            regs[wb.index]  <= wb.data;
            flags[wb.index] <= wb.flag;
        end
    end

    // both ports read without a clock, bypass lives in decode
    assign rd.a_data = regs[rd.ra];
    assign rd.b_data = regs[rd.rb];
    assign rd.flag_a = flags[rd.ra];
    assign rd.flag_b = flags[rd.rb];

endmodule

`default_nettype wire

/* verilog/decode_stage.sv */
`timescale 1ns/100ps
`default_nettype none

module decode_stage
(
    input  logic              clock,
    input  logic              arst_n,
    input  logic              head_valid,
    input  core_pkg::instr_t  head,
    output logic              pop,
    rd_port_if.reader         rd,
    wb_if.monitor             wb,
    stage_if.source           ex
);

    logic            hit_a;
    logic            hit_b;
    core_pkg::word_t a_value;
    core_pkg::word_t b_value;
    logic            a_flag;

    assign rd.ra = head.ra;
    assign rd.rb = head.rb;

    // the instruction in execute writes at the same edge we capture
    assign hit_a = wb.enable && (wb.index == head.ra);
    assign hit_b = wb.enable && (wb.index == head.rb);

    assign a_value = hit_a ? wb.data : rd.a_data;
    assign b_value = hit_b ? wb.data : rd.b_data;
    assign a_flag  = hit_a ? wb.flag : rd.flag_a;

    assign pop = head_valid && !ex.stall;

    always_ff @(posedge clock or negedge arst_n)
    begin
        if (!arst_n)
        begin
            ex.valid <= 1'b0;
        end
        else if (!ex.stall)
        begin
            ex.valid <= head_valid;
        end
    end

    // payload only moves on a pop, held through a stall
    always_ff @(posedge clock)
    begin
        if (pop)
        begin
            ex.opcode <= head.opcode;
            ex.rd     <= head.rd;
            ex.hl     <= head.hl;
            ex.value  <= head.value;
            ex.a      <= a_value;
            ex.b      <= b_value;
            ex.flag_a <= a_flag;
        end
    end

endmodule

`default_nettype wire

/* verilog/execute_stage.sv */
`timescale 1ns/100ps
`default_nettype none
`include "core_config.svh"

module execute_stage
(
    input  logic             clock,
    input  logic             arst_n,
    stage_if.sink            ex,
    wb_if.source             wb,
    output logic             store_valid,
    output core_pkg::word_t  store_address,
    output core_pkg::word_t  store_data,
    input  logic             store_credit
);

    localparam int STORE_CREDITS = `CORE_STORE_CREDITS;
    localparam int CREDIT_W      = $clog2(STORE_CREDITS + 1);

    logic [CREDIT_W-1:0] credits;
    logic                is_store;
    logic                store_fire;
    logic                carry_in;
    logic [32:0]         sum;
    core_pkg::word_t     result;
    logic                result_flag;
    logic                writes_reg;

    assign is_store   = ex.valid && (ex.opcode == core_pkg::STORE);
    assign ex.stall   = is_store && (credits == '0);
    assign store_fire = is_store && (credits != '0);

    assign carry_in = (ex.opcode == core_pkg::ADDC) ? ex.flag_a : 1'b0;
    assign sum      = {1'b0, ex.a} + {1'b0, ex.b} + {32'b0, carry_in};

    always_comb
    begin
        result      = '0;
        result_flag = 1'b0;
        writes_reg  = 1'b1;
        case (ex.opcode)
            core_pkg::ADD, core_pkg::ADDC:
            begin
                result      = sum[31:0];
                result_flag = sum[32];
            end
            core_pkg::SUB:
            begin
                result      = ex.a - ex.b;
                result_flag = (ex.a < ex.b);
            end
            core_pkg::AND:
            begin
                result      = ex.a & ex.b;
                result_flag = (result == '0);
            end
            core_pkg::OR:
            begin
                result      = ex.a | ex.b;
                result_flag = (result == '0);
            end
            core_pkg::XOR:
            begin
                result      = ex.a ^ ex.b;
                result_flag = (result == '0);
            end
            core_pkg::SHL:
            begin
                result      = ex.a << ex.b[4:0];
                result_flag = (result == '0);
            end
            core_pkg::SHR:
            begin
                result      = ex.a >> ex.b[4:0];
                result_flag = (result == '0);
            end
            // hl keeps the low half of ra and loads the upper half
            core_pkg::LDI:
            begin
                result = ex.hl ? {ex.value, ex.a[15:0]} : {16'b0, ex.value};
            end
            core_pkg::CMPEQ:
            begin
                result_flag = (ex.a == ex.b);
                result      = {31'b0, result_flag};
            end
            core_pkg::CMPLT:
            begin
                result_flag = (ex.a < ex.b);
                result      = {31'b0, result_flag};
            end
            core_pkg::SEL:
            begin
                result      = ex.flag_a ? ex.a : ex.b;
                result_flag = ex.flag_a;
            end
            default:
            begin
                writes_reg = 1'b0;
            end
        endcase
    end

    assign wb.enable = ex.valid && writes_reg && !ex.stall;
    assign wb.index  = ex.rd;
    assign wb.data   = result;
    assign wb.flag   = result_flag;

    // a credit returned this cycle counts from the next one
    always_ff @(posedge clock or negedge arst_n)
    begin
        if (!arst_n)
        begin
            credits     <= CREDIT_W'(STORE_CREDITS);
            store_valid <= 1'b0;
        end
        else
        begin
            case ({store_credit, store_fire})
                2'b10:   credits <= credits + 1'b1;
                2'b01:   credits <= credits - 1'b1;
                default: credits <= credits;
            endcase
            store_valid <= store_fire;
        end
    end

    always_ff @(posedge clock)
    begin
        if (store_fire)
        begin
            store_address <= ex.a + {16'b0, ex.value};
            store_data    <= ex.b;
        end
    end

endmodule

`default_nettype wire

/* verilog/stream_core.sv */
`timescale 1ns/100ps
`default_nettype none

module stream_core
(
    input  logic             clock,
    input  logic             arst_n,
    input  logic             instr_valid,
    input  core_pkg::word_t  instr,
    output logic             in_credit,
    output logic             store_valid,
    output core_pkg::word_t  store_address,
    output core_pkg::word_t  store_data,
    input  logic             store_credit
);

    logic             head_valid;
    core_pkg::instr_t head;
    logic             pop;

    rd_port_if rd_port ();
    wb_if      wb ();
    stage_if   stage ();

    issue_queue queue
    (
        .clock       (clock),
        .arst_n      (arst_n),
        .instr_valid (instr_valid),
        .instr       (instr),
        .in_credit   (in_credit),
        .head_valid  (head_valid),
        .head        (head),
        .pop         (pop)
    );

    decode_stage decode
    (
        .clock      (clock),
        .arst_n     (arst_n),
        .head_valid (head_valid),
        .head       (head),
        .pop        (pop),
        .rd         (rd_port.reader),
        .wb         (wb.monitor),
        .ex         (stage.source)
    );

    reg_file regs
    (
        .clock  (clock),
        .arst_n (arst_n),
        .rd     (rd_port.regs),
        .wb     (wb.sink)
    );

    execute_stage execute
    (
        .clock         (clock),
        .arst_n        (arst_n),
        .ex            (stage.sink),
        .wb            (wb.source),
        .store_valid   (store_valid),
        .store_address (store_address),
        .store_data    (store_data),
        .store_credit  (store_credit)
    );

endmodule

`default_nettype wire

/* sim/stream_core_tb.sv */
`timescale 1ns/100ps
`default_nettype none
`include "core_config.svh"

module stream_core_tb;

    localparam int TIMEOUT = 400;
    localparam int DEPTH   = `CORE_QUEUE_DEPTH;

    logic            clock;
    logic            arst_n;
    logic            instr_valid;
    core_pkg::word_t instr;
    logic            in_credit;
    logic            store_valid;
    core_pkg::word_t store_address;
    core_pkg::word_t store_data;
    logic            store_credit = 1'b0;

    integer            seed = 70856;
    integer            credit_seed = 70856;
    int                errors = 0;
    int                checks = 0;
    int                mark = 0;
    int                sent = 0;
    int                credit_pulses = 0;
    int                credits_held = DEPTH;
    int                stores_seen = 0;
    int                store_errors = 0;
    int                returned = 0;
    logic              withhold = 1'b0;
    core_pkg::word_t   m_regs [8] = '{default: '0};
    logic [7:0]        m_flags = '0;
    core_pkg::word_t   exp_addr [$];
    core_pkg::word_t   exp_data [$];
    core_pkg::opcode_e setters [4] = '{core_pkg::CMPEQ, core_pkg::CMPLT, core_pkg::SUB,
                                       core_pkg::ADD};

    stream_core DUT (.*);

    always #20 clock = ~clock;

    // outputs are sampled on the falling edge, away from the DUT's updates
    always @(negedge clock)
    begin
        // each valid cycle spends an input credit, each in_credit pulse returns one
        if (arst_n && instr_valid)
            credits_held--;
        if (arst_n && in_credit)
        begin
            credit_pulses++;
            credits_held++;
        end
        if (arst_n && store_valid)
        begin
            if (stores_seen >= exp_addr.size())
            begin
                $display("store to address %h arrived with no store expected", store_address);
                store_errors++;
            end
            else
                check_store(store_address, exp_addr[stores_seen], store_data,
                            exp_data[stores_seen]);
            stores_seen++;
        end
    end

    // the sink hands back one credit per store after a random delay
    always @(posedge clock)
    begin
        #2;
        if (!withhold && returned < stores_seen && ($random(credit_seed) & 3) == 0)
        begin
            store_credit = 1'b1;
            returned++;
        end
        else
            store_credit = 1'b0;
    end

    task automatic check_store(input core_pkg::word_t got_addr, input core_pkg::word_t want_addr,
                               input core_pkg::word_t got_data, input core_pkg::word_t want_data);
        if (got_addr !== want_addr)
            $display("FAILED store_address: got %h expected %h", got_addr, want_addr);
        if (got_data !== want_data)
            $display("FAILED store_data: got %h expected %h", got_data, want_data);
        if (got_addr !== want_addr || got_data !== want_data)
            store_errors++;
    endtask

    task automatic check_count(input string name, input int got, input int want);
        checks++;
        if (got != want)
        begin
            $display("FAILED %s: got %h expected %h", name, got, want);
            errors++;
        end
    endtask

    task automatic tick;
        @(posedge clock);
        #2;
    endtask

    function automatic core_pkg::reg_index_t random_reg();
        return 3'($random(seed));
    endfunction

    // ADD or one of SUB through LDI
    function automatic core_pkg::opcode_e alu_op();
        int n;
        n = int'($unsigned($random(seed)) % 8);
        return (n == 0) ? core_pkg::ADD : core_pkg::opcode_e'(n + 2);
    endfunction

    // reference model, one instruction at a time in stream order
    function automatic void model(input core_pkg::instr_t ins);
        core_pkg::word_t a;
        core_pkg::word_t b;
        core_pkg::word_t r;
        logic            f;
        a = m_regs[ins.ra];
        b = m_regs[ins.rb];
        r = '0;
        f = 1'b0;
        case (ins.opcode)
            core_pkg::ADD:   {f, r} = {1'b0, a} + {1'b0, b};
            core_pkg::ADDC:  {f, r} = {1'b0, a} + {1'b0, b} + {32'b0, m_flags[ins.ra]};
            core_pkg::SUB:   {f, r} = {a < b, a - b};
            core_pkg::AND:   r = a & b;
            core_pkg::OR:    r = a | b;
            core_pkg::XOR:   r = a ^ b;
            core_pkg::SHL:   r = a << b[4:0];
            core_pkg::SHR:   r = a >> b[4:0];
            core_pkg::LDI:   r = ins.hl ? {ins.value, a[15:0]} : {16'b0, ins.value};
            core_pkg::CMPEQ: {f, r} = {a == b, 31'b0, a == b};
            core_pkg::CMPLT: {f, r} = {a < b, 31'b0, a < b};
            core_pkg::SEL:   {f, r} = {m_flags[ins.ra], m_flags[ins.ra] ? a : b};
            default:         r = '0;
        endcase
        // logic ops and shifts flag a zero result
        if (ins.opcode >= core_pkg::AND && ins.opcode <= core_pkg::SHR)
            f = (r == '0);
        if (ins.opcode == core_pkg::STORE)
        begin
            exp_addr.push_back(a + 32'(ins.value));
            exp_data.push_back(b);
        end
        if (ins.opcode >= core_pkg::ADD && ins.opcode <= core_pkg::SEL)
        begin
            m_regs[ins.rd]  = r;
            m_flags[ins.rd] = f;
        end
    endfunction

    // waits for an input credit, then drives one instruction for one cycle
    task automatic send(input core_pkg::opcode_e op, input core_pkg::reg_index_t rd,
                        input core_pkg::reg_index_t ra, input core_pkg::reg_index_t rb,
                        input logic hl);
        core_pkg::instr_t ins;
        int               waited = 0;
        ins.opcode = op;
        ins.rd     = rd;
        ins.ra     = ra;
        ins.rb     = rb;
        ins.hl     = hl;
        ins.value  = 16'($random(seed));
        while (credits_held <= 0 && waited < TIMEOUT)
        begin
            tick();
            waited++;
        end
        if (credits_held <= 0)
        begin
            $display("timeout: no input credit came back, instruction dropped");
            errors++;
        end
        else
        begin
            instr_valid = 1'b1;
            instr       = ins;
            sent++;
            model(ins);
            tick();
            instr_valid = 1'b0;
        end
    endtask

    task automatic wait_drain;
        int waited = 0;
        while ((stores_seen < exp_addr.size() || credit_pulses < sent || returned != stores_seen)
               && waited < TIMEOUT)
        begin
            tick();
            waited++;
        end
        if (stores_seen < exp_addr.size() || credit_pulses < sent || returned != stores_seen)
        begin
            $display("timeout: stores or credits still outstanding after %0d cycles", TIMEOUT);
            errors++;
        end
    endtask

    task automatic report(input string name);
        $display("test %s finished with %0d errors", name, errors + store_errors - mark);
        mark = errors + store_errors;
    endtask

    initial
    begin
        int                   base;
        core_pkg::reg_index_t rd;
        core_pkg::reg_index_t prev;
        clock       = 1'b0;
        arst_n      = 1'b0;
        instr_valid = 1'b0;
        instr       = '0;

        repeat (8)
        begin
            @(negedge clock);
            check_count("in_credit in reset", int'(in_credit), 0);
            check_count("store_valid in reset", int'(store_valid), 0);
        end
        tick();
        arst_n = 1'b1;
        @(negedge clock);
        check_count("in_credit after reset", int'(in_credit), 0);
        check_count("store_valid after reset", int'(store_valid), 0);
        tick();
        for (int r = 0; r < 8; r++)
            send(core_pkg::STORE, 3'd0, 3'(r), 3'(r), 1'b0);
        wait_drain();
        report("reset");

        // both LDI halves into every register first
        for (int r = 0; r < 8; r++)
        begin
            send(core_pkg::LDI, 3'(r), 3'(r), 3'd0, 1'b0);
            send(core_pkg::LDI, 3'(r), 3'(r), 3'd0, 1'b1);
        end
        for (int i = 0; i < 60; i++)
        begin
            rd = random_reg();
            send(alu_op(), rd, random_reg(), random_reg(), 1'($random(seed)));
            send(core_pkg::STORE, 3'd0, random_reg(), rd, 1'b0);
        end
        wait_drain();
        report("alu");

        for (int i = 0; i < 40; i++)
        begin
            prev = random_reg();
            rd   = random_reg();
            send(setters[i % 4], prev, random_reg(), random_reg(), 1'b0);
            send(i[2] ? core_pkg::SEL : core_pkg::ADDC, rd, prev, random_reg(), 1'b0);
            send(core_pkg::STORE, 3'd0, random_reg(), rd, 1'b0);
        end
        wait_drain();
        report("flags");

        // each instruction reads the register written just before it
        prev = random_reg();
        for (int i = 0; i < 30; i++)
        begin
            rd = random_reg();
            send(alu_op(), rd, prev, prev, 1'($random(seed)));
            send(core_pkg::STORE, 3'd0, prev, rd, 1'b0);
            prev = rd;
        end
        wait_drain();
        report("bypass");

        withhold = 1'b1;
        tick();
        base = stores_seen;
        for (int i = 0; i < 6; i++)
            send(core_pkg::STORE, 3'd0, random_reg(), random_reg(), 1'b0);
        repeat (20) tick();
        check_count("stores while credits held", stores_seen - base, `CORE_STORE_CREDITS);
        withhold = 1'b0;
        wait_drain();
        report("backpressure");

        check_count("in_credit pulses", credit_pulses, sent);
        check_count("input credits held", credits_held, DEPTH);
        check_count("unchecked stores", exp_addr.size() - stores_seen, 0);
        report("credits");

        $display("%0d checks, %0d stores, %0d errors", checks, stores_seen,
                 errors + store_errors);
        if (errors + store_errors == 0)
        begin
            $display("TESTBENCH PASSED");
        end
        else
        begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* stream_core.f */
+incdir+verilog
verilog/core_pkg.sv
verilog/core_ifs.sv
verilog/issue_queue.sv
verilog/reg_file.sv
verilog/decode_stage.sv
verilog/execute_stage.sv
verilog/stream_core.sv
sim/stream_core_tb.sv

/* run_sim.sh */
#!/bin/sh
# build the testbench with Verilator, run it, and scan the log
verilator --binary -f stream_core.f --top-module stream_core_tb -o stream_core_sim \
    && ./obj_dir/stream_core_sim > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "build or run did not complete"; exit 1; }
cat sim.log
grep -q "TESTBENCH FAILED" sim.log && exit 1 || exit 0
